//--- verilog.f
src/isa_pkg.sv
src/ooo_pkg.sv
src/psel_gen.sv
src/rs.sv
src/alu_unit.sv
src/mult_unit.sv
src/cdb_arbiter.sv
src/issue_top.sv
tb/issue_tb.sv

//--- Bender.yml
package:
  name: issue_stage

sources:
  - src/isa_pkg.sv
  - src/ooo_pkg.sv
  - src/psel_gen.sv
  - src/rs.sv
  - src/alu_unit.sv
  - src/mult_unit.sv
  - src/cdb_arbiter.sv
  - src/issue_top.sv
  - target: test
    files:
      - tb/issue_tb.sv

//--- tb/issue_tb.sv
`timescale 1ns/1ps

module issue_tb
    import isa_pkg::*, ooo_pkg::*;
;

    localparam int RS_SIZE      = 8;
    localparam int NUM_ALU      = 2;
    localparam int MULT_STAGES  = 3;
    localparam int TAGS         = 64;   // one round uses every tag once
    localparam int STALL_LIMIT  = 1000;
    localparam int DRAIN_LIMIT  = 2000;

    logic                clock;
    logic                reset;
    dispatch_packet_t    dispatch;
    logic                almost_full;
    cdb_packet_t [N-1:0] cdb;

    logic [31:0] lfsr;
    string       test_name;
    logic [31:0] exp_val [TAGS];
    int          src_a [TAGS];
    int          src_b [TAGS];
    int          bc_cycle [TAGS];   // -1 until broadcast
    int          alloc;
    int          bc_count;
    int          cycle;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          failed_tests;

    issue_top #(
        .RS_SIZE    (RS_SIZE),
        .NUM_ALU    (NUM_ALU),
        .MULT_STAGES(MULT_STAGES)
    ) issue_top_inst (
        .clock      (clock),
        .reset      (reset),
        .dispatch   (dispatch),
        .almost_full(almost_full),
        .cdb        (cdb)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // galois form, one shift per bit
    function automatic logic next_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_model(input alu_func_e f, input logic [31:0] a,
                                              input logic [31:0] b);
        case (f)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] mult_model(input mult_func_e f, input logic [31:0] a,
                                               input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        p;
        sa = $signed({{32{a[31]}}, a});
        sb = $signed({{32{b[31]}}, b});
        ua = {32'd0, a};
        ub = {32'd0, b};
        case (f)
            MULT_MULH:   p = sa * sb;
            MULT_MULHSU: p = sa * $signed(ub); // ub top half is zero
            default:     p = ua * ub;
        endcase
        return (f == MULT_MUL) ? p[31:0] : p[63:32];
    endfunction

    task automatic show_mismatch(input int tag, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("[ERROR] %s tag %0d: expected %08h actual %08h",
                 test_name, tag, expected, actual);
        test_errors++;
    endtask

    task automatic record_fault(input string msg);
        $display("%s: %s", test_name, msg);
        test_errors++;
    endtask

    // bus is stable at the falling edge
    task automatic observe_bus();
        int valid_n;
        int t;
        valid_n = 0;
        for (int k = 0; k < N; k++) begin
            if (cdb[k].valid) begin
                if (valid_n != k) begin // results fill the bus from slot 0
                    record_fault($sformatf("bus slot %0d valid after an empty slot", k));
                end
                valid_n++;
                t = int'(cdb[k].dest_prn);
                if (t >= alloc) begin
                    record_fault($sformatf("bus slot %0d carries unallocated tag %0d", k, t));
                end else if (bc_cycle[t] >= 0) begin
                    record_fault($sformatf("tag %0d broadcast a second time", t));
                end else begin
                    if (cdb[k].value !== exp_val[t]) begin
                        show_mismatch(t, exp_val[t], cdb[k].value);
                    end
                    if ((src_a[t] >= 0 && (bc_cycle[src_a[t]] < 0 || bc_cycle[src_a[t]] >= cycle))
                        || (src_b[t] >= 0 && (bc_cycle[src_b[t]] < 0 ||
                                              bc_cycle[src_b[t]] >= cycle))) begin
                        record_fault($sformatf("tag %0d broadcast before its sources", t));
                    end
                    bc_cycle[t] = cycle;
                    bc_count++;
                end
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clock);
        cycle++;
        observe_bus();
        dispatch = '0; // idle unless the caller fills it
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        alloc       = 0;
        bc_count    = 0;
        for (int t = 0; t < TAGS; t++) begin
            exp_val[t]  = '0;
            src_a[t]    = -1;
            src_b[t]    = -1;
            bc_cycle[t] = -1;
        end
        reset    = 1'b1;
        dispatch = '0;
        repeat (5) @(negedge clock);
        reset = 1'b0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok, %0d tags", test_name, bc_count);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    // immediate value, or a tag from earlier in the round
    task automatic pick_operand(input bit allow_dep, output operand_t op,
                                output logic [31:0] val, output int src);
        src = -1;
        if (allow_dep && alloc > 0 && rand_bits(1)) begin
            src = alloc - 1 - int'(rand_bits(3)) % alloc;
            val = exp_val[src];
            if (bc_cycle[src] >= 0) begin
                op = '{ready: 1'b1, word: val}; // already on the bus, read as value
            end else begin
                op = '{ready: 1'b0, word: 32'(src)};
            end
        end else begin
            val = rand_bits(32);
            op  = '{ready: 1'b1, word: val};
        end
    endtask

    task automatic build_entry(input int mode, output rs_entry_t e);
        logic [31:0] a;
        logic [31:0] b;
        bit          dep;
        e       = '0;
        e.valid = 1'b1;
        case (mode)
            1:       e.fu = FU_ALU;
            2:       e.fu = FU_MULT;
            5:       e.fu = (rand_bits(2) != 0) ? FU_MULT : FU_ALU;
            default: e.fu = (rand_bits(2) == 0) ? FU_MULT : FU_ALU;
        endcase
        dep = (mode >= 3);
        if (e.fu == FU_MULT) begin
            e.func.mult = mult_func_e'(3'(rand_bits(2)));
        end else begin
            e.func.alu = alu_func_e'(3'(rand_bits(3)));
        end
        pick_operand(dep, e.op1, a, src_a[alloc]);
        pick_operand(dep, e.op2, b, src_b[alloc]);
        exp_val[alloc] = (e.fu == FU_MULT) ? mult_model(e.func.mult, a, b)
                                           : alu_model(e.func.alu, a, b);
        e.dest_prn = PRN_WIDTH'(alloc);
        alloc++;
    endtask

    task automatic run_round(input string name, input int mode);
        dispatch_packet_t d;
        rs_entry_t        e;
        int               n;
        int               guard;
        start_test(name);
        guard = 0;
        while (alloc < TAGS && guard < STALL_LIMIT) begin
            next_cycle();
            guard++;
            if (!almost_full) begin
                n = (mode == 4) ? 2 : int'(rand_bits(2));
                if (n > 2) begin
                    n = 2;
                end
                d = '0;
                for (int s = 0; s < n && alloc < TAGS; s++) begin
                    build_entry(mode, e);
                    d.entries[s] = e;
                end
                dispatch = d;
            end
        end
        if (alloc < TAGS) begin
            record_fault($sformatf("dispatch stalled after %0d tags", alloc));
        end
        guard = 0;
        while (bc_count < alloc && guard < DRAIN_LIMIT) begin
            next_cycle();
            guard++;
        end
        if (bc_count < alloc) begin
            record_fault($sformatf("timed out with %0d of %0d tags broadcast", bc_count, alloc));
        end
        finish_test();
    endtask

    task automatic check_reset_state();
        rs_entry_t e;
        int        disp_cycle;
        int        guard;
        start_test("reset_state");
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            if (almost_full !== 1'b0) begin
                record_fault("almost_full is not low after reset");
            end
            for (int k = 0; k < N; k++) begin
                if (cdb[k].valid !== 1'b0) begin
                    record_fault($sformatf("bus slot %0d valid before any dispatch", k));
                end
            end
        end
        build_entry(1, e);
        dispatch.entries[0] = e;
        disp_cycle = cycle;
        guard = 0;
        while (bc_count == 0 && guard < 50) begin
            next_cycle();
            guard++;
        end
        if (bc_count == 0) begin
            record_fault("first ALU result never appeared on the bus");
        end else if (bc_cycle[0] - disp_cycle < 2) begin
            record_fault($sformatf("first ALU result came %0d cycles after dispatch",
                                   bc_cycle[0] - disp_cycle));
        end
        finish_test();
    endtask

    initial begin
        reset        = 1'b1;
        dispatch     = '0;
        lfsr         = 32'ha46e535b;
        cycle        = 0;
        total_errors = 0;
        tests_run    = 0;
        failed_tests = 0;

        run_round("alu_immediate", 1);
        run_round("mult_functions", 2);
        run_round("dependent_chains", 3);
        run_round("burst_dispatch", 4);
        run_round("mult_backpressure", 5);
        check_reset_state();

        $display("tests %0d, failed %0d, errors %0d", tests_run, failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- src/issue_top.sv
`timescale 1ns/1ps

module issue_top
    import ooo_pkg::*;
#(
    parameter int RS_SIZE     = 8,
    parameter int NUM_ALU     = 2,
    parameter int MULT_STAGES = 3
)(
    input  logic                clock,
    input  logic                reset,
    input  dispatch_packet_t    dispatch,
    output logic                almost_full,
    output cdb_packet_t [N-1:0] cdb
);

    fu_packet_t [NUM_ALU-1:0] alu_packet;
    fu_packet_t               mult_packet;
    logic [NUM_ALU-1:0]       alu_avail;
    logic                     mult_avail;
    cdb_packet_t [NUM_ALU:0]  results;  // multiplier sits in the last slot
    logic [NUM_ALU:0]         grant;

    rs #(
        .RS_SIZE(RS_SIZE),
        .NUM_ALU(NUM_ALU)
    ) rs_inst (
        .clock      (clock),
        .reset      (reset),
        .dispatch   (dispatch),
        .cdb        (cdb),
        .alu_avail  (alu_avail),
        .mult_avail (mult_avail),
        .alu_packet (alu_packet),
        .mult_packet(mult_packet),
        .almost_full(almost_full)
    );

    for (genvar a = 0; a < NUM_ALU; a++) begin : g_alu
        alu_unit alu_inst (
            .clock (clock),
            .reset (reset),
            .packet(alu_packet[a]),
            .grant (grant[a]),
            .result(results[a]),
            .avail (alu_avail[a])
        );
    end

    mult_unit #(
        .MULT_STAGES(MULT_STAGES)
    ) mult_inst (
        .clock (clock),
        .reset (reset),
        .packet(mult_packet),
        .grant (grant[NUM_ALU]),
        .result(results[NUM_ALU]),
        .avail (mult_avail)
    );

    cdb_arbiter #(
        .NUM_ALU(NUM_ALU)
    ) cdb_arbiter_inst (
        .clock  (clock),
        .reset  (reset),
        .results(results),
        .grant  (grant),
        .cdb    (cdb)
    );

endmodule

//--- src/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter
    import ooo_pkg::*;
#(
    parameter int NUM_ALU = 2
)(
    input  logic                      clock,
    input  logic                      reset,
    input  cdb_packet_t [NUM_ALU:0]   results,
    output logic [NUM_ALU:0]          grant,
    output cdb_packet_t [N-1:0]       cdb
);

    localparam int UNITS     = NUM_ALU + 1;
    localparam int PTR_WIDTH = (UNITS > 1) ? $clog2(UNITS) : 1;

    logic [PTR_WIDTH-1:0] ptr;
    logic [PTR_WIDTH-1:0] next_ptr;
    logic [UNITS-1:0]     req;

    always_comb begin
        for (int u = 0; u < UNITS; u++) begin
            req[u] = results[u].valid;
        end
    end

    // walk units from ptr, fill bus slots in grant order
    always_comb begin
        int idx;
        int slot;
        grant    = '0;
        cdb      = '0;
        next_ptr = ptr;
        slot     = 0;
        for (int k = 0; k < UNITS; k++) begin
            idx = int'(ptr) + k;
            if (idx >= UNITS) begin
                idx = idx - UNITS;
            end
            if (req[idx] && slot < N) begin
                grant[idx] = 1'b1;
                cdb[slot]  = results[idx];
                slot       = slot + 1;
                next_ptr   = (idx == UNITS - 1) ? '0 : PTR_WIDTH'(idx + 1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ptr <= '0;
        end else begin
            ptr <= next_ptr;
        end
    end

    // a losing unit must hold its result unchanged
    for (genvar u = 0; u < UNITS; u++) begin : g_hold
        assert property (@(posedge clock) disable iff (reset)
            results[u].valid && !grant[u] |=> results[u].valid && $stable(results[u]));
    end

endmodule

//--- src/mult_unit.sv
`timescale 1ns/1ps

module mult_unit
    import isa_pkg::*, ooo_pkg::*;
#(
    parameter int MULT_STAGES = 3
)(
    input  logic        clock,
    input  logic        reset,
    input  fu_packet_t  packet,
    input  logic        grant,
    output cdb_packet_t result,
    output logic        avail
);

    typedef struct packed {
        logic                 high;    // take upper word at the end
        logic [PRN_WIDTH-1:0] tag;
        logic [2*XLEN-1:0]    product;
    } stage_t;

    logic                     a_sign;
    logic                     b_sign;
    logic [2*XLEN-1:0]        a_ext;
    logic [2*XLEN-1:0]        b_ext;
    stage_t                   stage_in;
    logic [MULT_STAGES-1:0]   stage_valid;
    stage_t [MULT_STAGES-1:0] stages;
    logic                     stall;

    // extend per function, then one 64-bit product
    assign a_sign = (packet.func.mult != MULT_MULHU) && packet.op1[XLEN-1];
    assign b_sign = (packet.func.mult == MULT_MUL || packet.func.mult == MULT_MULH)
                    && packet.op2[XLEN-1];
    assign a_ext  = {{XLEN{a_sign}}, packet.op1};
    assign b_ext  = {{XLEN{b_sign}}, packet.op2};

    assign stage_in = '{
        high:    packet.func.mult != MULT_MUL,
        tag:     packet.dest_prn,
        product: a_ext * b_ext
    };

    assign stall = stage_valid[MULT_STAGES-1] && !grant; // whole pipe freezes
    assign avail = !stall;

    always_ff @(posedge clock) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (!stall) begin
            stage_valid[0] <= packet.valid;
            for (int s = 1; s < MULT_STAGES; s++) begin
                stage_valid[s] <= stage_valid[s-1];
            end
        end
        if (!stall) begin
            stages[0] <= stage_in;
            for (int s = 1; s < MULT_STAGES; s++) begin
                stages[s] <= stages[s-1];
            end
        end
    end

    assign result.valid    = stage_valid[MULT_STAGES-1];
    assign result.dest_prn = stages[MULT_STAGES-1].tag;
    assign result.value    = stages[MULT_STAGES-1].high ?
                             stages[MULT_STAGES-1].product[2*XLEN-1:XLEN] :
                             stages[MULT_STAGES-1].product[XLEN-1:0];

    // station must respect back-pressure
    assert property (@(posedge clock) disable iff (reset) packet.valid |-> avail);

endmodule

//--- src/alu_unit.sv
`timescale 1ns/1ps

module alu_unit
    import isa_pkg::*, ooo_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  fu_packet_t  packet,
    input  logic        grant,
    output cdb_packet_t result,
    output logic        avail
);

    logic [XLEN-1:0]      value;
    logic                 result_valid;
    logic [PRN_WIDTH-1:0] result_tag;
    logic [XLEN-1:0]      result_value;

    always_comb begin
        case (packet.func.alu)
            ALU_ADD: value = packet.op1 + packet.op2;
            ALU_SUB: value = packet.op1 - packet.op2;
            ALU_AND: value = packet.op1 & packet.op2;
            ALU_OR:  value = packet.op1 | packet.op2;
            ALU_XOR: value = packet.op1 ^ packet.op2;
            ALU_SLL: value = packet.op1 << packet.op2[4:0];
            ALU_SRL: value = packet.op1 >> packet.op2[4:0];
            ALU_SLT: value = {{(XLEN-1){1'b0}}, $signed(packet.op1) < $signed(packet.op2)};
        endcase
    end

    assign avail = !result_valid || grant; // free, or emptying this cycle

    always_ff @(posedge clock) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else if (packet.valid) begin
            result_valid <= 1'b1;
        end else if (grant) begin
            result_valid <= 1'b0;
        end
        if (packet.valid) begin
            result_tag   <= packet.dest_prn;
            result_value <= value;
        end
    end

    assign result = '{valid: result_valid, dest_prn: result_tag, value: result_value};

endmodule

//--- src/rs.sv
`timescale 1ns/1ps

module rs
    import isa_pkg::*, ooo_pkg::*;
#(
    parameter int RS_SIZE = 8,
    parameter int NUM_ALU = 2
)(
    input  logic                      clock,
    input  logic                      reset,
    input  dispatch_packet_t          dispatch,
    input  cdb_packet_t [N-1:0]       cdb,
    input  logic [NUM_ALU-1:0]        alu_avail,
    input  logic                      mult_avail,
    output fu_packet_t [NUM_ALU-1:0]  alu_packet,
    output fu_packet_t                mult_packet,
    output logic                      almost_full
);

    localparam int CNT_WIDTH = $clog2(RS_SIZE + 1);

    logic [CNT_WIDTH-1:0]             count;
    logic [CNT_WIDTH-1:0]             next_count;
    rs_entry_t [RS_SIZE-1:0]          entries;
    rs_entry_t [RS_SIZE-1:0]          next_entries;

    logic [RS_SIZE-1:0]               ready;
    logic [RS_SIZE-1:0]               alu_req;
    logic [RS_SIZE-1:0]               mult_req;
    logic [NUM_ALU-1:0][RS_SIZE-1:0]  alu_gnt_bus;
    logic [0:0][RS_SIZE-1:0]          mult_gnt_bus;
    logic [RS_SIZE-1:0]               free_mask;
    logic                             placed;

    function automatic fu_packet_t to_packet(input rs_entry_t e);
        fu_packet_t p;
        p.valid    = 1'b1;
        p.func     = e.func;
        p.op1      = e.op1.word;
        p.op2      = e.op2.word;
        p.dest_prn = e.dest_prn;
        return p;
    endfunction

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            ready[i]    = entries[i].valid && entries[i].op1.ready && entries[i].op2.ready;
            alu_req[i]  = ready[i] && (entries[i].fu == FU_ALU);
            mult_req[i] = ready[i] && (entries[i].fu == FU_MULT);
        end
    end

    psel_gen #(
        .WIDTH(RS_SIZE),
        .REQS (NUM_ALU)
    ) alu_selector (
        .req    (alu_req),
        .gnt    (),
        .gnt_bus(alu_gnt_bus),
        .empty  ()
    );

    psel_gen #(
        .WIDTH(RS_SIZE),
        .REQS (1)
    ) mult_selector (
        .req    (mult_req),
        .gnt    (),
        .gnt_bus(mult_gnt_bus),
        .empty  ()
    );

    always_comb begin
        next_entries = entries;
        next_count   = count;
        placed       = 1'b0;
        for (int i = 0; i < RS_SIZE; i++) begin
            free_mask[i] = !entries[i].valid;
        end

        // slots fill the lowest free entries, in slot order
        if (!almost_full) begin
            for (int s = 0; s < N; s++) begin
                if (dispatch.entries[s].valid) begin
                    placed = 1'b0;
                    for (int i = 0; i < RS_SIZE; i++) begin
                        if (free_mask[i] && !placed) begin
                            next_entries[i] = dispatch.entries[s];
                            free_mask[i]    = 1'b0;
                            placed          = 1'b1;
                        end
                    end
                    next_count = next_count + 1'b1;
                end
            end
        end

        // wakeup also covers entries written this cycle
        for (int i = 0; i < RS_SIZE; i++) begin
            for (int k = 0; k < N; k++) begin
                if (cdb[k].valid) begin
                    if (!next_entries[i].op1.ready &&
                        next_entries[i].op1.word[PRN_WIDTH-1:0] == cdb[k].dest_prn) begin
                        next_entries[i].op1.ready = 1'b1;
                        next_entries[i].op1.word  = cdb[k].value;
                    end
                    if (!next_entries[i].op2.ready &&
                        next_entries[i].op2.word[PRN_WIDTH-1:0] == cdb[k].dest_prn) begin
                        next_entries[i].op2.ready = 1'b1;
                        next_entries[i].op2.word  = cdb[k].value;
                    end
                end
            end
        end

        // a grant only sticks when the unit can take it
        alu_packet  = '0;
        mult_packet = '0;
        for (int i = 0; i < RS_SIZE; i++) begin
            for (int j = 0; j < NUM_ALU; j++) begin
                if (alu_gnt_bus[j][i] && alu_avail[j]) begin
                    alu_packet[j]         = to_packet(entries[i]);
                    next_entries[i].valid = 1'b0;
                    next_count            = next_count - 1'b1;
                end
            end
            if (mult_gnt_bus[0][i] && mult_avail) begin
                mult_packet           = to_packet(entries[i]);
                next_entries[i].valid = 1'b0;
                next_count            = next_count - 1'b1;
            end
        end
    end

    assign almost_full = (count > RS_SIZE - N); // leaves room for a full packet

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
            for (int i = 0; i < RS_SIZE; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            count   <= next_count;
            entries <= next_entries;
        end
    end

    assert property (@(posedge clock) disable iff (reset) count <= RS_SIZE);

    // while full, only issue may change the count
    assert property (@(posedge clock) disable iff (reset)
        almost_full |=> count <= $past(count));

endmodule

//--- src/psel_gen.sv
`timescale 1ns/1ps

module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
)(
    input  logic [WIDTH-1:0]            req,
    output logic [WIDTH-1:0]            gnt,
    output logic [REQS-1:0][WIDTH-1:0]  gnt_bus,
    output logic                        empty
);

    logic [WIDTH-1:0] remaining;

    // each row peels off the lowest request still left
    always_comb begin
        remaining = req;
        gnt       = '0;
        gnt_bus   = '0;
        for (int r = 0; r < REQS; r++) begin
            gnt_bus[r] = remaining & (~remaining + 1'b1); // isolate lowest set bit
            remaining  = remaining & ~gnt_bus[r];
            gnt        = gnt | gnt_bus[r];
        end
    end

    assign empty = (req == '0);

endmodule

//--- src/ooo_pkg.sv
package ooo_pkg;

    import isa_pkg::*;

    localparam int N         = 2; // dispatch width and bus width
    localparam int PRN_WIDTH = 6;

    // word is a value when ready, else a tag in the low bits
    typedef struct packed {
        logic            ready;
        logic [XLEN-1:0] word;
    } operand_t;

    typedef struct packed {
        logic                 valid;
        fu_class_e            fu;
        func_u                func;
        operand_t             op1;
        operand_t             op2;
        logic [PRN_WIDTH-1:0] dest_prn;
    } rs_entry_t;

    // slot 0 is the older instruction
    typedef struct packed {
        rs_entry_t [N-1:0] entries;
    } dispatch_packet_t;

    // operands are always values once issued
    typedef struct packed {
        logic                 valid;
        func_u                func;
        logic [XLEN-1:0]      op1;
        logic [XLEN-1:0]      op2;
        logic [PRN_WIDTH-1:0] dest_prn;
    } fu_packet_t;

    typedef struct packed {
        logic                 valid;
        logic [PRN_WIDTH-1:0] dest_prn;
        logic [XLEN-1:0]      value;
    } cdb_packet_t;

endpackage

//--- src/isa_pkg.sv
package isa_pkg;

    localparam int XLEN = 32;

    // which unit class executes the entry
    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_class_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7  // signed compare
    } alu_func_e;

    typedef enum logic [2:0] {
        MULT_MUL    = 3'd0, // low word
        MULT_MULH   = 3'd1, // signed x signed, high word
        MULT_MULHSU = 3'd2, // signed x unsigned, high word
        MULT_MULHU  = 3'd3  // unsigned x unsigned, high word
    } mult_func_e;

    // same three bits, read according to the unit class
    typedef union packed {
        alu_func_e  alu;
        mult_func_e mult;
    } func_u;

endpackage
